// ==== verilog/sram_cfg.svh ====
`ifndef SRAM_CFG_SVH
`define SRAM_CFG_SVH

// external SRAM word address width
// 2^20 words of 32 bits, 4 MiB in all
`define SRAM_ADDR_BITS 20

// wishbone byte address width on both ports
`define BUS_ADDR_BITS 32

// data word width, shared by the buses and the SRAM pins
// one byte select per 8 bits
`define DATA_BITS 32

`endif

// ==== verilog/sram_pkg.sv ====
`default_nettype none

package sram_pkg;

`include "sram_cfg.svh"

    typedef logic [`DATA_BITS-1:0]       word_t;
    typedef logic [`BUS_ADDR_BITS-1:0]   byte_addr_t;
    typedef logic [`SRAM_ADDR_BITS-1:0]  ram_addr_t;
    typedef logic [`DATA_BITS/8-1:0]     mask_t;      // one bit per byte lane

    typedef enum logic [0:0] {
        PORT_I = 1'b0,  // instruction fetch
        PORT_D = 1'b1   // data
    } port_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } phy_state_t;

    // master side of one wishbone classic port
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        byte_addr_t adr;
        word_t      dat;
        mask_t      sel;
    } wb_req_t;

    typedef struct packed {
        logic  ack;
        logic  err;
        word_t dat;
    } wb_rsp_t;

    // granted access, arbiter to sequencer
    typedef struct packed {
        logic      valid;
        logic      write;
        logic      err;
        port_t     port;
        ram_addr_t addr;
        word_t     data;
        mask_t     be;
    } sram_req_t;

    // finished access, sequencer to router
    typedef struct packed {
        logic  valid;
        logic  err;
        port_t port;
        word_t rdata;
        mask_t be;
    } sram_done_t;

endpackage

`default_nettype wire

// ==== verilog/sram_req_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sram_cfg.svh"

module sram_req_arbiter (
    input  wire                  clk,
    input  wire                  rst,

    input  wire sram_pkg::wb_req_t ibus,
    input  wire sram_pkg::wb_req_t dbus,

    input  wire                  idle,     // sequencer can take a request
    output sram_pkg::sram_req_t  req
);

    logic                 i_pend;
    logic                 d_pend;
    sram_pkg::port_t      last_grant;
    sram_pkg::port_t      pick;
    sram_pkg::wb_req_t    sel_bus;
    sram_pkg::byte_addr_t adr;
    logic                 out_of_range;

    // classic wishbone, a cycle is live only with cyc and stb
    assign i_pend = ibus.cyc & ibus.stb;
    assign d_pend = dbus.cyc & dbus.stb;

    // round robin between the two ports
    always_comb begin
        if (i_pend && d_pend) begin
            if (last_grant == sram_pkg::PORT_I) begin
                pick = sram_pkg::PORT_D;
            end else begin
                pick = sram_pkg::PORT_I;
            end
        end else if (d_pend) begin
            pick = sram_pkg::PORT_D;
        end else begin
            pick = sram_pkg::PORT_I;
        end
    end

    assign sel_bus = (pick == sram_pkg::PORT_D) ? dbus : ibus;
    assign adr     = sel_bus.adr;

    // anything above the word range never goes to the pins
    assign out_of_range = |adr[`BUS_ADDR_BITS-1:`SRAM_ADDR_BITS+2];

    always_comb begin
        req.valid = idle & (i_pend | d_pend);
        req.write = sel_bus.we;
        req.err   = out_of_range;
        req.port  = pick;
        req.addr  = adr[`SRAM_ADDR_BITS+1:2];  // drop byte offset
        req.data  = sel_bus.dat;
        req.be    = sel_bus.sel;
    end

    // fetch wins the first tie after reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_grant <= sram_pkg::PORT_D;
        end else if (req.valid) begin
            last_grant <= pick;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/sram_phy_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_phy_fsm (
    input  wire                     clk,
    input  wire                     rst,

    input  wire sram_pkg::sram_req_t req,
    output logic                    idle,
    output sram_pkg::sram_done_t    done,

    // async SRAM pins
    inout  wire sram_pkg::word_t    ram_data,
    output sram_pkg::ram_addr_t     ram_addr,
    output sram_pkg::mask_t         ram_be_n,
    output logic                    ram_ce_n,
    output logic                    ram_oe_n,
    output logic                    ram_we_n
);

    sram_pkg::phy_state_t state;
    logic                 drive_en;   // write data on the pins
    logic                 accept;
    sram_pkg::word_t      wdata;
    sram_pkg::word_t      rdata;
    sram_pkg::port_t      cur_port;
    sram_pkg::mask_t      cur_be;
    logic                 cur_err;

    assign idle   = (state == sram_pkg::IDLE);
    assign accept = idle & req.valid;

    assign ram_data = drive_en ? wdata : 'z;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= sram_pkg::IDLE;
            ram_ce_n <= 1'b1;
            ram_oe_n <= 1'b1;
            ram_we_n <= 1'b1;
            ram_be_n <= '1;
            drive_en <= 1'b0;
        end else begin
            case (state)
                sram_pkg::IDLE: begin
                    if (req.valid) begin
                        if (req.err) begin
                            state <= sram_pkg::DONE;  // no pin activity
                        end else begin
                            state    <= sram_pkg::ACCESS;
                            ram_ce_n <= 1'b0;
                            ram_oe_n <= req.write;
                            ram_we_n <= ~req.write;
                            ram_be_n <= ~req.be;
                            drive_en <= req.write;
                        end
                    end
                end
                sram_pkg::ACCESS: begin
                    // single strobe cycle, then release everything
                    state    <= sram_pkg::DONE;
                    ram_ce_n <= 1'b1;
                    ram_oe_n <= 1'b1;
                    ram_we_n <= 1'b1;
                    ram_be_n <= '1;
                    drive_en <= 1'b0;
                end
                sram_pkg::DONE: begin
                    state <= sram_pkg::IDLE;
                end
                default: begin
                    state <= sram_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ram_addr <= req.addr;
            wdata    <= req.data;
            cur_port <= req.port;
            cur_be   <= req.be;
            cur_err  <= req.err;
            rdata    <= '0;   // err completions return zeros
        end
        // on a write this picks up the word being driven
        if (state == sram_pkg::ACCESS) begin
            rdata <= ram_data;
        end
    end

    always_comb begin
        done.valid = (state == sram_pkg::DONE);
        done.err   = cur_err;
        done.port  = cur_port;
        done.rdata = rdata;
        done.be    = cur_be;
    end

endmodule

`default_nettype wire

// ==== verilog/wb_resp_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_resp_router (
    input  wire                      clk,
    input  wire                      rst,

    input  wire sram_pkg::sram_done_t done,

    output sram_pkg::wb_rsp_t        ibus_rsp,
    output sram_pkg::wb_rsp_t        dbus_rsp
);

    localparam int LANES = $bits(sram_pkg::mask_t);

    sram_pkg::word_t masked;
    sram_pkg::word_t i_dat;
    sram_pkg::word_t d_dat;
    logic            to_i;
    logic            to_d;

    assign to_i = done.valid & (done.port == sram_pkg::PORT_I);
    assign to_d = done.valid & (done.port == sram_pkg::PORT_D);

    // unselected lanes read as zero
    always_comb begin
        for (int b = 0; b < LANES; b++) begin
            masked[8*b +: 8] = done.be[b] ? done.rdata[8*b +: 8] : 8'h00;
        end
    end

    // dat holds until that port completes again
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            i_dat <= '0;
            d_dat <= '0;
        end else begin
            if (to_i) begin
                i_dat <= masked;
            end
            if (to_d) begin
                d_dat <= masked;
            end
        end
    end

    always_comb begin
        ibus_rsp.ack = to_i & ~done.err;
        ibus_rsp.err = to_i & done.err;
        ibus_rsp.dat = to_i ? masked : i_dat;   // same cycle as ack
        dbus_rsp.ack = to_d & ~done.err;
        dbus_rsp.err = to_d & done.err;
        dbus_rsp.dat = to_d ? masked : d_dat;
    end

endmodule

`default_nettype wire

// ==== verilog/dual_wb_sram_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_wb_sram_top (
    input  wire                     clk,
    input  wire                     rst,

    // fetch and data wishbone slaves
    input  wire sram_pkg::wb_req_t  ibus,
    input  wire sram_pkg::wb_req_t  dbus,
    output sram_pkg::wb_rsp_t       ibus_rsp,
    output sram_pkg::wb_rsp_t       dbus_rsp,

    // external SRAM
    inout  wire sram_pkg::word_t    ram_data,
    output sram_pkg::ram_addr_t     ram_addr,
    output sram_pkg::mask_t         ram_be_n,
    output logic                    ram_ce_n,
    output logic                    ram_oe_n,
    output logic                    ram_we_n
);

    sram_pkg::sram_req_t  req;
    sram_pkg::sram_done_t done;
    logic                 idle;

    sram_req_arbiter u_arbiter (
        .clk  (clk),
        .rst  (rst),
        .ibus (ibus),
        .dbus (dbus),
        .idle (idle),
        .req  (req)
    );

    // one access at a time on the pins
    sram_phy_fsm u_phy (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .idle     (idle),
        .done     (done),
        .ram_data (ram_data),
        .ram_addr (ram_addr),
        .ram_be_n (ram_be_n),
        .ram_ce_n (ram_ce_n),
        .ram_oe_n (ram_oe_n),
        .ram_we_n (ram_we_n)
    );

    wb_resp_router u_router (
        .clk      (clk),
        .rst      (rst),
        .done     (done),
        .ibus_rsp (ibus_rsp),
        .dbus_rsp (dbus_rsp)
    );

endmodule

`default_nettype wire

// ==== verification/sram_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module sram_model (
    inout  wire sram_pkg::word_t     ram_data,
    input  wire sram_pkg::ram_addr_t ram_addr,
    input  wire sram_pkg::mask_t     ram_be_n,
    input  wire                      ram_ce_n,
    input  wire                      ram_oe_n,
    input  wire                      ram_we_n
);

    sram_pkg::word_t mem [sram_pkg::ram_addr_t];
    sram_pkg::word_t rd_word;

    // unwritten words read back a pattern made from the address
    function automatic sram_pkg::word_t peek(input sram_pkg::ram_addr_t a);
        return mem.exists(a) ? mem[a] : {12'h5c3, a};
    endfunction

    always @(ram_addr or ram_ce_n or ram_oe_n or ram_we_n) begin
        rd_word = peek(ram_addr);
    end

    assign ram_data = (!ram_ce_n && !ram_oe_n && ram_we_n) ? rd_word : 'z;  // all lanes

    // data has settled shortly after the strobe falls
    always @(negedge ram_we_n) begin : write_cycle
        sram_pkg::word_t w;
        #1;
        if (!ram_ce_n && !ram_we_n) begin
            w = peek(ram_addr);
            for (int b = 0; b < $bits(sram_pkg::mask_t); b++) begin
                if (!ram_be_n[b]) w[8*b +: 8] = ram_data[8*b +: 8];
            end
            mem[ram_addr] = w;
        end
    end

endmodule

`default_nettype wire

// ==== verification/dual_wb_sram_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module dual_wb_sram_props (
    input wire                      clk,
    input wire                      rst,
    input wire sram_pkg::wb_rsp_t   ibus_rsp,
    input wire sram_pkg::wb_rsp_t   dbus_rsp,
    input wire                      ram_ce_n,
    input wire                      ram_oe_n,
    input wire                      ram_we_n,
    input wire                      idle,
    input wire sram_pkg::sram_req_t req
);

    int unsigned fail_count = 0;
    logic        i_rsp;
    logic        d_rsp;

    assign i_rsp = ibus_rsp.ack | ibus_rsp.err;
    assign d_rsp = dbus_rsp.ack | dbus_rsp.err;

    ibus_pulse: assert property (@(posedge clk) disable iff (rst) i_rsp |=> !i_rsp)
        else begin
            $error("ibus ack or err lasted more than one cycle");
            fail_count++;
        end

    dbus_pulse: assert property (@(posedge clk) disable iff (rst) d_rsp |=> !d_rsp)
        else begin
            $error("dbus ack or err lasted more than one cycle");
            fail_count++;
        end

    // read and write strobes are exclusive
    no_bus_fight: assert property (@(posedge clk) !(!ram_we_n && !ram_oe_n))
        else begin
            $error("ram_we_n and ram_oe_n low together");
            fail_count++;
        end

    strobes_in_reset: assert property (@(posedge clk) rst |-> (ram_ce_n && ram_oe_n && ram_we_n))
        else begin
            $error("SRAM strobe active during reset");
            fail_count++;
        end

    completes: assert property (@(posedge clk) disable iff (rst)
        (idle && req.valid) |-> ##[1:20] (i_rsp || d_rsp))
        else begin
            $error("accepted request got no ack or err within 20 cycles");
            fail_count++;
        end

endmodule

`default_nettype wire

// ==== verification/dual_wb_sram_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "sram_cfg.svh"

module dual_wb_sram_tb;

    logic                 clk = 1'b0;
    logic                 rst;
    sram_pkg::wb_req_t    ibus;
    sram_pkg::wb_req_t    dbus;
    sram_pkg::wb_rsp_t    ibus_rsp;
    sram_pkg::wb_rsp_t    dbus_rsp;
    wire sram_pkg::word_t ram_data;
    sram_pkg::ram_addr_t  ram_addr;
    sram_pkg::mask_t      ram_be_n;
    logic                 ram_ce_n;
    logic                 ram_oe_n;
    logic                 ram_we_n;

    logic [31:0]          lfsr = 32'd35;
    sram_pkg::word_t      sb [sram_pkg::ram_addr_t];   // expected memory
    sram_pkg::ram_addr_t  addrs [$];
    int                   checks = 0;
    int                   errors = 0;
    int                   tests = 0;
    int                   mark_chk = 0;
    int                   mark_err = 0;
    logic                 ce_low_seen = 1'b0;
    sram_pkg::ram_addr_t  pin_addr = '0;   // word address seen while ram_ce_n was low

    always #20 clk = ~clk;

    dual_wb_sram_top u_dual_wb_sram_top (.*);
    sram_model u_sram (.*);
    bind dual_wb_sram_top dual_wb_sram_props u_props (.*);

    // galois LFSR stepped once per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic sram_pkg::word_t merge_lanes(input sram_pkg::word_t old_w,
            input sram_pkg::word_t new_w, input sram_pkg::mask_t sel);
        sram_pkg::word_t w;
        w = old_w;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) w[8*b +: 8] = new_w[8*b +: 8];
        end
        return w;
    endfunction

    function automatic sram_pkg::byte_addr_t byte_addr(input sram_pkg::ram_addr_t a);
        return {{(`BUS_ADDR_BITS - `SRAM_ADDR_BITS - 2){1'b0}}, a, 2'b00};
    endfunction

    function automatic sram_pkg::wb_req_t make_req(input logic we, input sram_pkg::byte_addr_t adr,
            input sram_pkg::word_t d, input sram_pkg::mask_t sel);
        return '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: d, sel: sel};
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s: %0d checks, %0d errors", name, checks - mark_chk, errors - mark_err);
        mark_chk = checks;
        mark_err = errors;
    endtask

    task automatic finish_run(input string reason);
        if (reason != "") $display("run aborted: %s", reason);
        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_dual_wb_sram_top.u_props.fail_count);
        if (reason == "" && errors == 0 && u_dual_wb_sram_top.u_props.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // i_at and d_at count cycles from the first possible accepting edge
    task automatic run_access(input sram_pkg::wb_req_t ireq, input sram_pkg::wb_req_t dreq,
            output sram_pkg::wb_rsp_t irsp, output sram_pkg::wb_rsp_t drsp,
            output int i_at, output int d_at);
        int n;
        n = 0;
        i_at = 0;
        d_at = 0;
        irsp = '0;
        drsp = '0;
        ce_low_seen = 1'b0;
        ibus = ireq;
        dbus = dreq;
        while ((ibus.stb || dbus.stb) && n < 20) begin
            @(negedge clk);
            n++;
            if (!ram_ce_n) begin
                ce_low_seen = 1'b1;
                pin_addr = ram_addr;
            end
            if (ibus.stb && (ibus_rsp.ack || ibus_rsp.err)) begin
                irsp = ibus_rsp;
                i_at = n - 1;
            end
            if (dbus.stb && (dbus_rsp.ack || dbus_rsp.err)) begin
                drsp = dbus_rsp;
                d_at = n - 1;
            end
            @(posedge clk);
            #2;
            if (irsp.ack || irsp.err) ibus = '0;
            if (drsp.ack || drsp.err) dbus = '0;
        end
        if (ibus.stb || dbus.stb) finish_run("a request got no ack or err within 20 cycles");
    endtask

    // one uncontended access with the scoreboard updated on writes and compared on reads
    task automatic check_access(input sram_pkg::port_t port, input logic we,
            input sram_pkg::ram_addr_t a, input sram_pkg::word_t d,
            input sram_pkg::mask_t sel, input string name);
        sram_pkg::wb_req_t req;
        sram_pkg::wb_rsp_t irsp;
        sram_pkg::wb_rsp_t drsp;
        int                i_at;
        int                d_at;
        req = make_req(we, byte_addr(a), d, sel);
        if (port == sram_pkg::PORT_I) begin
            run_access(req, '0, irsp, drsp, i_at, d_at);
            drsp = irsp;
            d_at = i_at;
        end else begin
            run_access('0, req, irsp, drsp, i_at, d_at);
        end
        check_value({name, " ack"}, 1, drsp.ack);
        check_value({name, " latency"}, 2, d_at);
        check_value({name, " ram_ce_n low"}, 1, ce_low_seen);
        check_value({name, " ram_addr"}, a, pin_addr);
        if (we) begin
            sb[a] = merge_lanes(sb.exists(a) ? sb[a] : '0, d, sel);
        end else begin
            check_value({name, " data"}, merge_lanes('0, sb[a], sel), drsp.dat);
        end
    endtask

    initial begin : main
        sram_pkg::ram_addr_t a;
        sram_pkg::word_t     d;
        sram_pkg::wb_rsp_t   irsp;
        sram_pkg::wb_rsp_t   drsp;
        int                  i_at;
        int                  d_at;
        int                  bad_bit;
        rst  = 1'b1;
        ibus = '0;
        dbus = '0;
        repeat (2) @(posedge clk);
        #2;
        rst = 1'b0;

        @(negedge clk);
        check_value("reset strobes", 3'b111, {ram_ce_n, ram_oe_n, ram_we_n});
        check_value("reset responses", 0,
                    {ibus_rsp.ack, ibus_rsp.err, dbus_rsp.ack, dbus_rsp.err});
        end_test("reset_idle");
        @(posedge clk);
        #2;

        for (int i = 0; i < 4; i++) begin
            a = take_bits(`SRAM_ADDR_BITS);
            addrs.push_back(a);
            check_access(sram_pkg::PORT_D, 1'b1, a, take_bits(32), 4'hf, "full_word write");
            check_access(sram_pkg::PORT_D, 1'b0, a, '0, 4'hf, "full_word read");
        end
        end_test("full_word");

        foreach (addrs[i]) begin
            check_access(sram_pkg::PORT_D, 1'b1, addrs[i], take_bits(32), take_bits(4),
                         "byte_lanes write");
            check_access(sram_pkg::PORT_D, 1'b0, addrs[i], '0, take_bits(4), "byte_lanes read");
        end
        end_test("byte_lanes");

        foreach (addrs[i]) begin
            check_access(sram_pkg::PORT_I, 1'b0, addrs[i], '0, 4'hf, "cross_port read");
        end
        end_test("cross_port");

        // last grant was dbus so the fetch goes first
        check_access(sram_pkg::PORT_D, 1'b1, addrs[0], take_bits(32), 4'hf, "arbitration setup");
        d = take_bits(32);
        run_access(make_req(1'b0, byte_addr(addrs[1]), '0, 4'hf),
                   make_req(1'b1, byte_addr(addrs[2]), d, 4'hf), irsp, drsp, i_at, d_at);
        check_value("arbitration ibus first", 1, i_at < d_at);
        check_value("arbitration ibus data", sb[addrs[1]], irsp.dat);
        check_value("arbitration dbus ack", 1, drsp.ack);
        sb[addrs[2]] = d;
        // last grant ibus now
        check_access(sram_pkg::PORT_I, 1'b0, addrs[2], '0, 4'hf, "arbitration setup");
        run_access(make_req(1'b0, byte_addr(addrs[3]), '0, 4'hf),
                   make_req(1'b0, byte_addr(addrs[0]), '0, 4'hf), irsp, drsp, i_at, d_at);
        check_value("arbitration dbus first", 1, d_at < i_at);
        check_value("arbitration ibus data", sb[addrs[3]], irsp.dat);
        check_value("arbitration dbus data", sb[addrs[0]], drsp.dat);
        end_test("arbitration");

        // aliases addrs[0] in the low bits
        bad_bit = `SRAM_ADDR_BITS + 2 + (take_bits(4) % (`BUS_ADDR_BITS - `SRAM_ADDR_BITS - 2));
        run_access('0, make_req(1'b1, byte_addr(addrs[0]) | (32'd1 << bad_bit), take_bits(32),
                   4'hf), irsp, drsp, i_at, d_at);
        check_value("bad_addr err", 1, drsp.err);
        check_value("bad_addr ack", 0, drsp.ack);
        check_value("bad_addr latency", 1, d_at);
        check_value("bad_addr ram_ce_n low", 0, ce_low_seen);
        check_access(sram_pkg::PORT_D, 1'b0, addrs[0], '0, 4'hf, "bad_addr memory");
        end_test("bad_addr");

        finish_run("");
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+verilog
verilog/sram_pkg.sv
verilog/sram_req_arbiter.sv
verilog/sram_phy_fsm.sv
verilog/wb_resp_router.sv
verilog/dual_wb_sram_top.sv
verification/sram_model.sv
verification/dual_wb_sram_props.sv
verification/dual_wb_sram_tb.sv

// ==== Bender.yml ====
package:
  name: dual_wb_sram

export_include_dirs:
  - verilog

sources:
  - files:
      - verilog/sram_pkg.sv
      - verilog/sram_req_arbiter.sv
      - verilog/sram_phy_fsm.sv
      - verilog/wb_resp_router.sv
      - verilog/dual_wb_sram_top.sv
  - target: simulation
    files:
      - verification/sram_model.sv
      - verification/dual_wb_sram_props.sv
      - verification/dual_wb_sram_tb.sv
